//--- design/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    localparam logic [XLEN-1:0] UART_TX_ADDR = 32'h0000_f000;  // above dmem range

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA,
        OP_OR, OP_AND, OP_LUI, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU,
        OP_BGEU, OP_JAL, OP_JALR, OP_LW, OP_SW, OP_SB, OP_NOP
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_PIPE = 2'd0,
        FWD_WB   = 2'd1
    } fwd_sel_e;

    typedef struct packed {
        word_t    pc;
        word_t    pc_plus;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    operand_a;
        word_t    operand_b;
        word_t    imm;
        alu_op_e  op;
        logic     use_imm;
        logic     wb_en;
    } de_ex_t;

    typedef struct packed {
        reg_idx_t        rd;
        word_t           result;
        logic            wb_en;
        logic            is_load;
        logic            is_store;
        logic [3:0]      byte_en;
        logic [XLEN-3:0] mem_addr;  // word index
        word_t           store_data;
        logic            uart_en;
    } ex_mem_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    data;
        logic     wb_en;
    } wb_t;

endpackage

//--- design/rv_hazard_control.sv
`timescale 1ns/1ps

module rv_hazard_control (
    input  logic             clk,
    input  logic             reset,
    input  logic             i_take,
    input  rv_pkg::reg_idx_t i_rs1,
    input  rv_pkg::reg_idx_t i_rs2,
    input  rv_pkg::wb_t      i_wb,
    output logic             o_flush,
    output rv_pkg::fwd_sel_e o_fwd_a,
    output rv_pkg::fwd_sel_e o_fwd_b
);
    import rv_pkg::*;

    function automatic fwd_sel_e pick_src(input reg_idx_t src, input wb_t wb);
        fwd_sel_e sel;
        sel = FWD_PIPE;
        if (wb.wb_en && (wb.rd != '0) && (wb.rd == src)) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    assign o_fwd_a = pick_src(i_rs1, i_wb);
    assign o_fwd_b = pick_src(i_rs2, i_wb);

    // kills the two younger slots one cycle after take
    always_ff @(posedge clk) begin
        if (reset) begin
            o_flush <= 1'b0;
        end else begin
            o_flush <= i_take;
        end
    end

endmodule

//--- design/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch (
    input  logic          clk,
    input  logic          reset,
    input  logic          i_flush,
    input  logic          i_take,
    input  rv_pkg::word_t i_target,
    output rv_pkg::word_t o_imem_addr,
    output rv_pkg::word_t o_pc_de,
    output logic          o_valid_de
);
    import rv_pkg::*;

    word_t pc;
    word_t pc_de;
    logic  valid_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= '0;
            valid_q <= 1'b0;
        end else begin
            pc      <= i_take ? i_target : pc + word_t'(4);
            valid_q <= 1'b1;  // first word returns a cycle after reset
        end
    end

    // pc of the word coming back from imem
    always_ff @(posedge clk) begin
        pc_de <= pc;
    end

    assign o_imem_addr = pc;
    assign o_pc_de     = pc_de;
    assign o_valid_de  = valid_q & ~i_flush;  // wrong-path word

endmodule

//--- design/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input  logic             clk,
    input  logic             reset,
    input  logic             i_flush,
    input  rv_pkg::inst_u    i_inst,
    input  rv_pkg::word_t    i_pc,
    input  logic             i_valid,
    output rv_pkg::reg_idx_t o_rs1,
    output rv_pkg::reg_idx_t o_rs2,
    input  rv_pkg::word_t    i_rdata1,
    input  rv_pkg::word_t    i_rdata2,
    output rv_pkg::de_ex_t   o_de_ex,
    output logic             o_valid_ex
);
    import rv_pkg::*;

    word_t  imm_i;
    word_t  imm_s;
    word_t  imm_b;
    word_t  imm_u;
    word_t  imm_j;
    de_ex_t de_d;
    de_ex_t de_q;
    logic   valid_q;

    assign o_rs1 = i_inst.r.rs1;
    assign o_rs2 = i_inst.r.rs2;

    assign imm_i = {{20{i_inst.i.imm_11_0[11]}}, i_inst.i.imm_11_0};
    assign imm_s = {{20{i_inst.s.imm_11_5[6]}}, i_inst.s.imm_11_5, i_inst.s.imm_4_0};
    assign imm_b = {{19{i_inst.b.imm_12}}, i_inst.b.imm_12, i_inst.b.imm_11,
                    i_inst.b.imm_10_5, i_inst.b.imm_4_1, 1'b0};
    assign imm_u = {i_inst.u.imm_31_12, 12'h000};
    assign imm_j = {{11{i_inst.j.imm_20}}, i_inst.j.imm_20, i_inst.j.imm_19_12,
                    i_inst.j.imm_11, i_inst.j.imm_10_1, 1'b0};

    always_comb begin
        de_d           = '0;
        de_d.pc        = i_pc;
        de_d.pc_plus   = i_pc + word_t'(4);
        de_d.rs1       = i_inst.r.rs1;
        de_d.rs2       = i_inst.r.rs2;
        de_d.rd        = i_inst.r.rd;
        de_d.operand_a = i_rdata1;
        de_d.operand_b = i_rdata2;
        de_d.imm       = imm_i;
        de_d.op        = OP_NOP;
        de_d.wb_en     = 1'b1;
        case (i_inst.r.opcode)
            OPC_LUI: begin
                de_d.op  = OP_LUI;
                de_d.imm = imm_u;
            end
            OPC_JAL: begin
                de_d.op  = OP_JAL;
                de_d.imm = imm_j;
            end
            OPC_JALR: begin
                de_d.op = (i_inst.i.funct3 == 3'b000) ? OP_JALR : OP_NOP;
            end
            OPC_BRANCH: begin
                de_d.imm   = imm_b;
                de_d.wb_en = 1'b0;
                case (i_inst.b.funct3)
                    3'b000:  de_d.op = OP_BEQ;
                    3'b001:  de_d.op = OP_BNE;
                    3'b100:  de_d.op = OP_BLT;
                    3'b101:  de_d.op = OP_BGE;
                    3'b110:  de_d.op = OP_BLTU;
                    3'b111:  de_d.op = OP_BGEU;
                    default: de_d.op = OP_NOP;
                endcase
            end
            OPC_LOAD: begin
                de_d.op = (i_inst.i.funct3 == 3'b010) ? OP_LW : OP_NOP;
            end
            OPC_STORE: begin
                de_d.imm   = imm_s;
                de_d.wb_en = 1'b0;
                case (i_inst.s.funct3)
                    3'b000:  de_d.op = OP_SB;
                    3'b010:  de_d.op = OP_SW;
                    default: de_d.op = OP_NOP;
                endcase
            end
            OPC_OP_IMM: begin
                de_d.use_imm = 1'b1;
                case (i_inst.i.funct3)
                    3'b000:  de_d.op = OP_ADD;
                    3'b010:  de_d.op = OP_SLT;
                    3'b011:  de_d.op = OP_SLTU;
                    3'b100:  de_d.op = OP_XOR;
                    3'b110:  de_d.op = OP_OR;
                    3'b111:  de_d.op = OP_AND;
                    3'b001:  de_d.op = (i_inst.r.funct7 == 7'b0000000) ? OP_SLL : OP_NOP;
                    default: begin  // srli / srai share funct3
                        if (i_inst.r.funct7 == 7'b0000000) begin
                            de_d.op = OP_SRL;
                        end else if (i_inst.r.funct7 == 7'b0100000) begin
                            de_d.op = OP_SRA;
                        end
                    end
                endcase
            end
            OPC_OP: begin
                case ({i_inst.r.funct7, i_inst.r.funct3})
                    {7'b0000000, 3'b000}: de_d.op = OP_ADD;
                    {7'b0100000, 3'b000}: de_d.op = OP_SUB;
                    {7'b0000000, 3'b001}: de_d.op = OP_SLL;
                    {7'b0000000, 3'b010}: de_d.op = OP_SLT;
                    {7'b0000000, 3'b011}: de_d.op = OP_SLTU;
                    {7'b0000000, 3'b100}: de_d.op = OP_XOR;
                    {7'b0000000, 3'b101}: de_d.op = OP_SRL;
                    {7'b0100000, 3'b101}: de_d.op = OP_SRA;
                    {7'b0000000, 3'b110}: de_d.op = OP_OR;
                    {7'b0000000, 3'b111}: de_d.op = OP_AND;
                    default:              de_d.op = OP_NOP;
                endcase
            end
            default: de_d.op = OP_NOP;
        endcase
        if (!i_valid) begin
            de_d.op = OP_NOP;  // bubble
        end
        if (de_d.op == OP_NOP) begin
            de_d.wb_en = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || i_flush) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        de_q <= de_d;
    end

    assign o_de_ex    = de_q;
    assign o_valid_ex = valid_q & ~i_flush;

endmodule

//--- design/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic             clk,
    input  rv_pkg::reg_idx_t i_raddr1,
    input  rv_pkg::reg_idx_t i_raddr2,
    output rv_pkg::word_t    o_rdata1,
    output rv_pkg::word_t    o_rdata2,
    input  rv_pkg::wb_t      i_wb
);
    import rv_pkg::*;

    word_t regs [1:31];  // x0 is not stored

    // write-through is the decode-stage bypass
    function automatic word_t read_port(input reg_idx_t idx);
        word_t data;
        if (idx == '0) begin
            data = '0;
        end else if (i_wb.wb_en && (i_wb.rd == idx)) begin
            data = i_wb.data;
        end else begin
            data = regs[idx];
        end
        return data;
    endfunction

    always_comb begin
        o_rdata1 = read_port(i_raddr1);
        o_rdata2 = read_port(i_raddr2);
    end

    always_ff @(posedge clk) begin
        if (i_wb.wb_en && (i_wb.rd != '0)) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

endmodule

//--- design/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
    input  rv_pkg::de_ex_t   i_de_ex,
    input  logic             i_valid,
    input  rv_pkg::fwd_sel_e i_fwd_a,
    input  rv_pkg::fwd_sel_e i_fwd_b,
    input  rv_pkg::wb_t      i_wb,
    output rv_pkg::ex_mem_t  o_ex_mem,
    output logic             o_take,
    output rv_pkg::word_t    o_target
);
    import rv_pkg::*;

    word_t src_a;
    word_t src_b;
    word_t alu_b;
    word_t addr;
    word_t result;
    logic  cond;
    logic  is_sb;
    logic  uart_hit;

    assign src_a = (i_fwd_a == FWD_WB) ? i_wb.data : i_de_ex.operand_a;
    assign src_b = (i_fwd_b == FWD_WB) ? i_wb.data : i_de_ex.operand_b;
    assign alu_b = i_de_ex.use_imm ? i_de_ex.imm : src_b;
    assign addr  = src_a + i_de_ex.imm;  // lw/sw/sb address and jalr target

    always_comb begin
        result = '0;
        cond   = 1'b0;
        case (i_de_ex.op)
            OP_ADD:  result = src_a + alu_b;
            OP_SUB:  result = src_a - alu_b;
            OP_SLL:  result = src_a << alu_b[4:0];
            OP_SLT:  result = word_t'($signed(src_a) < $signed(alu_b));
            OP_SLTU: result = word_t'(src_a < alu_b);
            OP_XOR:  result = src_a ^ alu_b;
            OP_SRL:  result = src_a >> alu_b[4:0];
            OP_SRA:  result = $signed(src_a) >>> alu_b[4:0];
            OP_OR:   result = src_a | alu_b;
            OP_AND:  result = src_a & alu_b;
            OP_LUI:  result = i_de_ex.imm;
            OP_BEQ:  cond   = (src_a == src_b);
            OP_BNE:  cond   = (src_a != src_b);
            OP_BLT:  cond   = ($signed(src_a) < $signed(src_b));
            OP_BGE:  cond   = ($signed(src_a) >= $signed(src_b));
            OP_BLTU: cond   = (src_a < src_b);
            OP_BGEU: cond   = (src_a >= src_b);
            OP_JAL, OP_JALR: begin
                result = i_de_ex.pc_plus;  // link
                cond   = 1'b1;
            end
            OP_LW, OP_SW, OP_SB: result = addr;
            default: result = '0;
        endcase
    end

    assign o_take   = i_valid & cond;
    assign o_target = (i_de_ex.op == OP_JALR) ? {addr[XLEN-1:1], 1'b0}
                                              : i_de_ex.pc + i_de_ex.imm;

    assign is_sb    = (i_de_ex.op == OP_SB);
    assign uart_hit = is_sb & (addr == UART_TX_ADDR);

    always_comb begin
        o_ex_mem            = '0;
        o_ex_mem.rd         = i_de_ex.rd;
        o_ex_mem.result     = result;
        o_ex_mem.wb_en      = i_valid & i_de_ex.wb_en;
        o_ex_mem.is_load    = i_valid & (i_de_ex.op == OP_LW);
        o_ex_mem.mem_addr   = addr[XLEN-1:2];
        o_ex_mem.byte_en    = is_sb ? (4'b0001 << addr[1:0]) : 4'b1111;
        o_ex_mem.store_data = is_sb ? (word_t'(src_b[7:0]) << {addr[1:0], 3'b000}) : src_b;
        o_ex_mem.uart_en    = i_valid & uart_hit;
        o_ex_mem.is_store   = i_valid & ((i_de_ex.op == OP_SW) | (is_sb & ~uart_hit));
    end

endmodule

//--- design/rv_mem_stage.sv
`timescale 1ns/1ps

module rv_mem_stage (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::ex_mem_t i_ex_mem,
    output rv_pkg::wb_t     o_wb,
    output logic            o_uart_en,
    output logic [7:0]      o_uart_data
);
    import rv_pkg::*;

    word_t              mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] word_idx;
    word_t              rdata_q;
    word_t              result_q;
    reg_idx_t           rd_q;
    logic               wb_en_q;
    logic               is_load_q;

    assign word_idx = i_ex_mem.mem_addr[DMEM_AW-1:0];

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (i_ex_mem.is_store && i_ex_mem.byte_en[lane]) begin
                mem[word_idx][lane*8 +: 8] <= i_ex_mem.store_data[lane*8 +: 8];
            end
        end
        rdata_q <= mem[word_idx];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_en_q   <= 1'b0;
            is_load_q <= 1'b0;
            o_uart_en <= 1'b0;
        end else begin
            wb_en_q   <= i_ex_mem.wb_en;
            is_load_q <= i_ex_mem.is_load;
            o_uart_en <= i_ex_mem.uart_en;
        end
    end

    always_ff @(posedge clk) begin
        rd_q        <= i_ex_mem.rd;
        result_q    <= i_ex_mem.result;
        o_uart_data <= i_ex_mem.store_data[7:0];  // uart address is lane 0
    end

    assign o_wb = '{rd: rd_q, data: (is_load_q ? rdata_q : result_q), wb_en: wb_en_q};

endmodule

//--- design/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic          clk,
    input  logic          reset,
    output rv_pkg::word_t o_imem_addr,
    input  rv_pkg::word_t i_imem_data,
    output logic          o_uart_en,
    output logic [7:0]    o_uart_data
);
    import rv_pkg::*;

    logic     flush;
    logic     take;
    word_t    target;
    word_t    pc_de;
    logic     valid_de;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rdata1;
    word_t    rdata2;
    de_ex_t   de_ex;
    logic     valid_ex;
    ex_mem_t  ex_mem;
    wb_t      wb;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    rv_fetch u_fetch (
        .clk         (clk),
        .reset       (reset),
        .i_flush     (flush),
        .i_take      (take),
        .i_target    (target),
        .o_imem_addr (o_imem_addr),
        .o_pc_de     (pc_de),
        .o_valid_de  (valid_de)
    );

    rv_decode u_decode (
        .clk        (clk),
        .reset      (reset),
        .i_flush    (flush),
        .i_inst     (inst_u'(i_imem_data)),
        .i_pc       (pc_de),
        .i_valid    (valid_de),
        .o_rs1      (rs1),
        .o_rs2      (rs2),
        .i_rdata1   (rdata1),
        .i_rdata2   (rdata2),
        .o_de_ex    (de_ex),
        .o_valid_ex (valid_ex)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .i_raddr1 (rs1),
        .i_raddr2 (rs2),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2),
        .i_wb     (wb)
    );

    rv_execute u_execute (
        .i_de_ex  (de_ex),
        .i_valid  (valid_ex),
        .i_fwd_a  (fwd_a),
        .i_fwd_b  (fwd_b),
        .i_wb     (wb),
        .o_ex_mem (ex_mem),
        .o_take   (take),
        .o_target (target)
    );

    rv_mem_stage u_mem_stage (
        .clk         (clk),
        .reset       (reset),
        .i_ex_mem    (ex_mem),
        .o_wb        (wb),
        .o_uart_en   (o_uart_en),
        .o_uart_data (o_uart_data)
    );

    rv_hazard_control u_hazard_control (
        .clk     (clk),
        .reset   (reset),
        .i_take  (take),
        .i_rs1   (de_ex.rs1),
        .i_rs2   (de_ex.rs2),
        .i_wb    (wb),
        .o_flush (flush),
        .o_fwd_a (fwd_a),
        .o_fwd_b (fwd_b)
    );

endmodule

//--- verification/rv_core_assertions.sv
`timescale 1ns/1ps

module rv_core_assertions (
    input logic          clk,
    input logic          reset,
    input rv_pkg::word_t i_imem_addr,
    input logic          i_uart_en
);
    int assert_fails = 0;

    // pc only moves in whole instructions
    a_fetch_aligned: assert property (@(posedge clk) disable iff (reset)
        i_imem_addr[1:0] == 2'b00)
    else begin
        assert_fails++;
        $error("fetch address %h is not word aligned", i_imem_addr);
    end

    a_uart_quiet_after_reset: assert property (@(posedge clk) reset |=> !i_uart_en)
    else begin
        assert_fails++;
        $error("uart strobe high in the cycle after reset");
    end

    a_uart_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(i_uart_en))
    else begin
        assert_fails++;
        $error("uart strobe is unknown");
    end

endmodule

bind rv_core rv_core_assertions i_assertions (
    .clk         (clk),
    .reset       (reset),
    .i_imem_addr (o_imem_addr),
    .i_uart_en   (o_uart_en)
);

//--- verification/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;
    import rv_pkg::*;

    localparam int          PROG_WORDS = 512;
    localparam int          TIMEOUT    = 2000;
    localparam logic [31:0] SEED       = 32'hce00_842c;
    localparam logic [7:0]  POISON     = 8'hee;
    localparam logic [7:0]  FALL       = 8'h5a;
    localparam reg_idx_t    UART_REG   = 5'd31;  // holds UART_TX_ADDR
    localparam reg_idx_t    TMP_REG    = 5'd4;
    localparam reg_idx_t    POISON_REG = 5'd23;
    localparam reg_idx_t    FALL_REG   = 5'd24;
    localparam word_t       NOP_WORD   = 32'h0000_0013;

    logic        clk;
    logic        reset;
    word_t       imem_addr;
    word_t       imem_data;
    logic        uart_en;
    logic [7:0]  uart_data;

    word_t       prog [PROG_WORDS];
    int          prog_len;
    word_t       fetch_addr;
    logic [7:0]  rx_q [$];
    logic [7:0]  exp_q [$];
    int          errors;
    int          checks;

    rv_core i_dut (
        .clk         (clk),
        .reset       (reset),
        .o_imem_addr (imem_addr),
        .i_imem_data (imem_data),
        .o_uart_en   (uart_en),
        .o_uart_data (uart_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // synchronous imem returns the word for last cycle's address
    always @(posedge clk) begin
        #1;
        imem_data  = $isunknown(fetch_addr) ? NOP_WORD : prog[fetch_addr[10:2]];
        fetch_addr = imem_addr;
    end

    always @(posedge clk) begin
        #1;
        if (uart_en === 1'b1) begin
            rx_q.push_back(uart_data);
        end
    end

    function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t enc_b(input logic [12:0] off, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input reg_idx_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic word_t enc_j(input logic [20:0] off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // architectural branch outcome
    function automatic bit branch_taken(input logic [2:0] f3, input word_t x, input word_t y);
        case (f3)
            3'b000:  return x == y;
            3'b001:  return x != y;
            3'b100:  return $signed(x) < $signed(y);
            3'b101:  return $signed(x) >= $signed(y);
            3'b110:  return x < y;
            default: return x >= y;
        endcase
    endfunction

    task automatic put(input word_t inst);
        prog[prog_len] = inst;
        prog_len++;
    endtask

    task automatic load_const(input reg_idx_t rd, input word_t value);
        word_t upper;
        upper = value + 32'h0000_0800;  // addi sign-extends the low part
        put(enc_u(upper[31:12], rd));
        put(enc_i(value[11:0], rd, 3'b000, rd, OPC_OP_IMM));
    endtask

    task automatic send_byte(input reg_idx_t rs, input logic [7:0] value);
        put(enc_s(12'h000, rs, UART_REG, 3'b000));
        exp_q.push_back(value);
    endtask

    // low byte first, then srli by 8, 16, 24
    task automatic send_word(input reg_idx_t rs, input word_t value);
        int k;
        put(enc_s(12'h000, rs, UART_REG, 3'b000));
        for (k = 1; k < 4; k++) begin
            put(enc_i(12'(8 * k), rs, 3'b101, TMP_REG, OPC_OP_IMM));
            put(enc_s(12'h000, TMP_REG, UART_REG, 3'b000));
        end
        for (k = 0; k < 4; k++) begin
            exp_q.push_back(value[8*k +: 8]);
        end
    endtask

    task automatic put_poison_pair();
        put(enc_s(12'h000, POISON_REG, UART_REG, 3'b000));
        put(enc_s(12'h000, POISON_REG, UART_REG, 3'b000));
    endtask

    task automatic begin_program();
        int k;
        @(posedge clk);
        #1;
        reset = 1'b1;
        for (k = 0; k < PROG_WORDS; k++) begin
            prog[k] = NOP_WORD;
        end
        prog_len = 0;
        exp_q.delete();
        put(enc_u(UART_TX_ADDR[31:12], UART_REG));
        put(enc_i(12'(POISON), 5'd0, 3'b000, POISON_REG, OPC_OP_IMM));
        put(enc_i(12'(FALL), 5'd0, 3'b000, FALL_REG, OPC_OP_IMM));
    endtask

    task automatic check_uart_byte(input logic [7:0] expected, input logic [7:0] actual,
                                   input string name, input int idx);
        checks++;
        if (actual !== expected) begin
            $display("error at %0d ns: %s uart byte %0d expected %02h, got %02h",
                     $time, name, idx, expected, actual);
            errors++;
        end
    endtask

    task automatic run_program(input string name, input bit check_poison);
        word_t halt_addr;
        int    seen;
        int    cycles;
        int    k;
        halt_addr = word_t'(prog_len * 4);
        put(enc_j(21'd0, 5'd0));  // jal x0 to itself
        repeat (5) @(posedge clk);
        #1;
        rx_q.delete();
        reset  = 1'b0;
        seen   = 0;
        cycles = 0;
        // halt fetched a second time means every older instruction retired
        while ((seen < 2) && (cycles < TIMEOUT)) begin
            @(posedge clk);
            #1;
            cycles++;
            if (imem_addr == halt_addr) begin
                seen++;
            end
        end
        if (seen < 2) begin
            $display("timeout: %s did not reach its halt loop within %0d cycles",
                     name, TIMEOUT);
            errors++;
        end
        checks++;
        if (rx_q.size() != exp_q.size()) begin
            $display("error at %0d ns: %s sent %0d uart bytes, expected %0d",
                     $time, name, rx_q.size(), exp_q.size());
            errors++;
        end
        for (k = 0; (k < exp_q.size()) && (k < rx_q.size()); k++) begin
            check_uart_byte(exp_q[k], rx_q[k], name, k);
        end
        if (check_poison) begin
            foreach (rx_q[n]) begin
                if (rx_q[n] == POISON) begin
                    $display("%s: a flushed instruction reached the uart (byte %0d)",
                             name, n);
                    errors++;
                end
            end
        end
    endtask

    task automatic alu_rr(input logic [6:0] f7, input logic [2:0] f3, input word_t exp);
        put(enc_r(f7, 5'd2, 5'd1, f3, 5'd3));
        send_word(5'd3, exp);
    endtask

    task automatic alu_ri(input logic [11:0] imm, input logic [2:0] f3, input word_t exp);
        put(enc_i(imm, 5'd1, f3, 5'd3, OPC_OP_IMM));
        send_word(5'd3, exp);
    endtask

    task automatic test_alu();
        word_t       a;
        word_t       b;
        logic [11:0] imm;
        word_t       immx;
        logic [4:0]  sh;
        logic [19:0] up;
        a    = $urandom();
        b    = $urandom();
        imm  = 12'($urandom());
        immx = {{20{imm[11]}}, imm};
        sh   = 5'($urandom());
        up   = 20'($urandom());
        begin_program();
        load_const(5'd1, a);
        load_const(5'd2, b);
        alu_rr(7'h00, 3'b000, a + b);
        alu_rr(7'h20, 3'b000, a - b);
        alu_rr(7'h00, 3'b001, a << b[4:0]);
        alu_rr(7'h00, 3'b010, word_t'($signed(a) < $signed(b)));
        alu_rr(7'h00, 3'b011, word_t'(a < b));
        alu_rr(7'h00, 3'b100, a ^ b);
        alu_rr(7'h00, 3'b101, a >> b[4:0]);
        alu_rr(7'h20, 3'b101, word_t'($signed(a) >>> b[4:0]));
        alu_rr(7'h00, 3'b110, a | b);
        alu_rr(7'h00, 3'b111, a & b);
        alu_ri(imm, 3'b000, a + immx);
        alu_ri(imm, 3'b010, word_t'($signed(a) < $signed(immx)));
        alu_ri(imm, 3'b011, word_t'(a < immx));
        alu_ri(imm, 3'b100, a ^ immx);
        alu_ri(imm, 3'b110, a | immx);
        alu_ri(imm, 3'b111, a & immx);
        alu_ri({7'h00, sh}, 3'b001, a << sh);
        alu_ri({7'h00, sh}, 3'b101, a >> sh);
        alu_ri({7'h20, sh}, 3'b101, word_t'($signed(a) >>> sh));
        put(enc_u(up, 5'd3));
        send_word(5'd3, {up, 12'h000});
        run_program("alu", 1'b0);
    endtask

    task automatic test_forwarding();
        word_t r5;
        word_t r6;
        word_t r7;
        word_t r8;
        word_t r9;
        word_t r11;
        r5  = $urandom();
        r6  = r5 + 32'h0000_0123;
        r7  = r6 + r5;
        r8  = r7 - r6;
        r9  = r8 ^ r5;
        r11 = r9 + r9;  // x10 reloads r9
        begin_program();
        load_const(5'd5, r5);
        put(enc_i(12'h123, 5'd5, 3'b000, 5'd6, OPC_OP_IMM));
        put(enc_r(7'h00, 5'd5, 5'd6, 3'b000, 5'd7));
        put(enc_r(7'h20, 5'd6, 5'd7, 3'b000, 5'd8));
        put(enc_r(7'h00, 5'd5, 5'd8, 3'b100, 5'd9));
        put(enc_s(12'h040, 5'd9, 5'd0, 3'b010));          // sw x9, 64(x0)
        put(enc_i(12'h040, 5'd0, 3'b010, 5'd10, OPC_LOAD));
        put(enc_r(7'h00, 5'd9, 5'd10, 3'b000, 5'd11));    // load result used at once
        send_word(5'd11, r11);
        put(enc_u(UART_TX_ADDR[31:12], 5'd12));
        put(enc_s(12'h000, 5'd7, 5'd12, 3'b000));         // base comes from wb
        exp_q.push_back(r7[7:0]);
        send_byte(5'd6, r6[7:0]);
        send_byte(5'd8, r8[7:0]);
        send_byte(5'd9, r9[7:0]);
        run_program("forwarding", 1'b0);
    endtask

    task automatic branch_case(input logic [2:0] f3, input reg_idx_t rs1, input reg_idx_t rs2,
                               input word_t x, input word_t y, input logic [7:0] tag);
        bit       taken;
        reg_idx_t skip_reg;
        taken    = branch_taken(f3, x, y);
        skip_reg = taken ? POISON_REG : FALL_REG;
        put(enc_i(12'(tag), 5'd0, 3'b000, 5'd22, OPC_OP_IMM));
        put(enc_b(13'd12, rs2, rs1, f3));
        put(enc_s(12'h000, skip_reg, UART_REG, 3'b000));
        put(enc_s(12'h000, skip_reg, UART_REG, 3'b000));
        put(enc_s(12'h000, 5'd22, UART_REG, 3'b000));
        if (!taken) begin
            exp_q.push_back(FALL);
            exp_q.push_back(FALL);
        end
        exp_q.push_back(tag);
    endtask

    task automatic test_branches();
        word_t      a;
        word_t      b;
        logic [2:0] f3s [6];
        int         tag;
        a   = $urandom() | 32'h8000_0000;  // negative but large unsigned
        b   = $urandom() & 32'h7fff_ffff;
        f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        tag = 1;
        begin_program();
        load_const(5'd1, a);
        load_const(5'd2, b);
        foreach (f3s[n]) begin
            branch_case(f3s[n], 5'd1, 5'd1, a, a, 8'(tag));
            branch_case(f3s[n], 5'd1, 5'd2, a, b, 8'(tag + 1));
            branch_case(f3s[n], 5'd2, 5'd1, b, a, 8'(tag + 2));
            tag = tag + 3;
        end
        run_program("branches", 1'b1);
    endtask

    task automatic test_jumps();
        int    k;
        word_t link1;
        word_t link2;
        begin_program();
        link1 = word_t'(prog_len * 4 + 4);
        put(enc_j(21'd12, 5'd5));
        put_poison_pair();
        send_byte(5'd5, link1[7:0]);
        k = prog_len;
        // base + 4 is odd and jalr drops bit 0
        put(enc_i(12'((k + 4) * 4 - 3), 5'd0, 3'b000, 5'd6, OPC_OP_IMM));
        put(enc_i(12'h004, 5'd6, 3'b000, 5'd7, OPC_JALR));
        link2 = word_t'((k + 2) * 4);
        put_poison_pair();
        send_byte(5'd7, link2[7:0]);
        run_program("jumps", 1'b1);
    endtask

    task automatic test_memory();
        word_t      w;
        word_t      merged;
        logic [7:0] bv;
        int         lane;
        w      = $urandom();
        merged = $urandom();
        begin_program();
        load_const(5'd1, w);
        put(enc_s(12'h080, 5'd1, 5'd0, 3'b010));
        put(enc_i(12'h080, 5'd0, 3'b010, 5'd2, OPC_LOAD));
        send_word(5'd2, w);
        load_const(5'd1, merged);
        put(enc_s(12'h084, 5'd1, 5'd0, 3'b010));
        for (lane = 0; lane < 4; lane++) begin
            bv = 8'($urandom());
            merged[8*lane +: 8] = bv;
            put(enc_i(12'(bv), 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
            put(enc_s(12'(32'h84 + lane), 5'd3, 5'd0, 3'b000));
            put(enc_i(12'h084, 5'd0, 3'b010, 5'd5, OPC_LOAD));
            send_word(5'd5, merged);
        end
        put(enc_u(20'habcde, 5'd0));
        put(enc_i(12'h055, 5'd0, 3'b000, 5'd0, OPC_OP_IMM));
        send_byte(5'd0, 8'h00);
        put(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd9));
        send_word(5'd9, 32'h0000_0000);
        run_program("memory", 1'b0);
    endtask

    initial begin
        reset     = 1'b1;
        imem_data = NOP_WORD;
        prog_len  = 0;
        errors    = 0;
        checks    = 0;
        void'($urandom(SEED));
        test_alu();
        test_forwarding();
        test_branches();
        test_jumps();
        test_memory();
        errors = errors + i_dut.i_assertions.assert_fails;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, i_dut.i_assertions.assert_fails);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
design/rv_pkg.sv
design/rv_hazard_control.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_mem_stage.sv
design/rv_core.sv
verification/rv_core_assertions.sv
verification/rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - design/rv_pkg.sv
      - design/rv_hazard_control.sv
      - design/rv_fetch.sv
      - design/rv_decode.sv
      - design/rv_regfile.sv
      - design/rv_execute.sv
      - design/rv_mem_stage.sv
      - design/rv_core.sv
  - target: simulation
    files:
      - verification/rv_core_assertions.sv
      - verification/rv_core_tb.sv
